// ==== hdl/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

  localparam int REG_BITS = 5;

  typedef logic [REG_BITS-1:0] reg_idx_t;

  // groups 00 reg alu, 01 imm alu, 10 memory, 11 jumps.
  typedef logic [5:0] opcode_t;

  localparam opcode_t OP_NOP = 6'b000000;
  localparam opcode_t OP_JR  = 6'b001000; // special inside reg alu group.
  localparam opcode_t OP_LW  = 6'b100011;
  localparam opcode_t OP_SW  = 6'b101011;
  localparam opcode_t OP_LA  = 6'b100100;
  localparam opcode_t OP_SA  = 6'b101100;

  typedef struct packed {
    opcode_t  opcode;
    reg_idx_t rs;
    reg_idx_t rt;
    reg_idx_t rd;
  } instr_t;

  localparam instr_t BUBBLE_INSTR = '{opcode: OP_NOP, rs: '0, rt: '0, rd: '0};

  typedef struct packed {
    logic rs;
    logic rt;
    logic rd;
  } operand_mask_t;

  typedef enum logic [1:0] {
    MEM_NONE,
    MEM_READ,
    MEM_WRITE
  } mem_op_t;

  typedef struct packed {
    operand_mask_t src;
    operand_mask_t dst;
    mem_op_t       mem_op;
  } decoded_t;

endpackage

`default_nettype wire

// ==== hdl/pipe_pkg.sv ====
`default_nettype none

package pipe_pkg;

  // one bit per pipe register.
  typedef logic [2:0] pipe_mask_t;

  localparam pipe_mask_t PIPE_PC    = 3'b001;
  localparam pipe_mask_t PIPE_IF_ID = 3'b010;
  localparam pipe_mask_t PIPE_ID_EX = 3'b100;

  typedef struct packed {
    pipe_mask_t stall0;
    pipe_mask_t nop0;
    pipe_mask_t stall1;
    pipe_mask_t nop1;
  } hazard_ctl_t;

  typedef struct packed {
    isa_pkg::instr_t  instr;
    isa_pkg::mem_op_t mem_op;
  } ex_entry_t;

  localparam ex_entry_t BUBBLE_EX = '{
    instr:  isa_pkg::BUBBLE_INSTR,
    mem_op: isa_pkg::MEM_NONE
  };

endpackage

`default_nettype wire

// ==== hdl/operand_decoder.sv ====
`timescale 1ns/100ps
`default_nettype none

module operand_decoder (
  input  isa_pkg::opcode_t  opcode,
  output isa_pkg::decoded_t dec
);

  import isa_pkg::*;

  always_comb begin
    dec.src    = '0;
    dec.dst    = '0;
    dec.mem_op = MEM_NONE;

    case (opcode[5:4])
      2'b00: begin
        case (opcode)
          OP_NOP: begin
          end
          OP_JR: begin
            dec.src.rs = 1'b1;
          end
          default: begin // add, sub and friends.
            dec.src.rs = 1'b1;
            dec.src.rt = 1'b1;
            dec.dst.rd = 1'b1;
          end
        endcase
      end
      2'b01: begin // immediate forms.
        dec.src.rs = 1'b1;
        dec.dst.rt = 1'b1;
      end
      2'b10: begin
        case (opcode)
          OP_LW: begin
            dec.src.rs = 1'b1;
            dec.dst.rt = 1'b1;
            dec.mem_op = MEM_READ;
          end
          OP_SW: begin
            dec.src.rs = 1'b1;
            dec.src.rt = 1'b1;
            dec.mem_op = MEM_WRITE;
          end
          OP_LA: begin
            dec.dst.rt = 1'b1;
          end
          OP_SA: begin
            dec.src.rt = 1'b1;
            dec.mem_op = MEM_WRITE;
          end
          default: begin // unused memory encodings.
          end
        endcase
      end
      default: begin // jumps touch no register.
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== hdl/pipe_stage_reg.sv ====
`timescale 1ns/100ps
`default_nettype none

module pipe_stage_reg #(
  parameter type      payload_t = logic,
  parameter payload_t BUBBLE    = '0
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     stall,
  input  logic     nop,
  input  payload_t d,
  output payload_t q
);

  always_ff @(posedge clk) begin
    if (rst) begin
      q <= BUBBLE;
    end else if (nop) begin // bubble beats hold.
      q <= BUBBLE;
    end else if (!stall) begin
      q <= d;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/decode_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module decode_stage #(
  parameter logic [31:0] RESET_PC = 32'h0
) (
  input  logic                  clk,
  input  logic                  rst,
  input  isa_pkg::instr_t       fetch0,
  input  isa_pkg::instr_t       fetch1,
  input  logic                  first,
  input  pipe_pkg::hazard_ctl_t ctl,
  output logic [31:0]           pc,
  output isa_pkg::instr_t       if_id0,
  output isa_pkg::instr_t       if_id1,
  output logic                  if_id_first,
  output isa_pkg::decoded_t     dec0,
  output isa_pkg::decoded_t     dec1
);

  import isa_pkg::*;
  import pipe_pkg::*;

  logic pc_hold;
  logic if_id_stall0;
  logic if_id_stall1;
  logic if_id_nop0;
  logic if_id_nop1;

  // either slot may freeze fetch.
  assign pc_hold = |((ctl.stall0 | ctl.stall1) & PIPE_PC);

  assign if_id_stall0 = |(ctl.stall0 & PIPE_IF_ID);
  assign if_id_stall1 = |(ctl.stall1 & PIPE_IF_ID);
  assign if_id_nop0   = |(ctl.nop0 & PIPE_IF_ID);
  assign if_id_nop1   = |(ctl.nop1 & PIPE_IF_ID);

  always_ff @(posedge clk) begin
    if (rst) begin
      pc          <= RESET_PC;
      if_id_first <= 1'b0;
    end else begin
      if (!pc_hold) begin
        pc <= pc + 32'd2; // one pair per cycle.
      end
      if (!if_id_stall0) begin
        if_id_first <= first; // follows slot 0.
      end
    end
  end

  pipe_stage_reg #(
    .payload_t (instr_t),
    .BUBBLE    (BUBBLE_INSTR)
  ) i_if_id0_reg (
    .clk   (clk),
    .rst   (rst),
    .stall (if_id_stall0),
    .nop   (if_id_nop0),
    .d     (fetch0),
    .q     (if_id0)
  );

  pipe_stage_reg #(
    .payload_t (instr_t),
    .BUBBLE    (BUBBLE_INSTR)
  ) i_if_id1_reg (
    .clk   (clk),
    .rst   (rst),
    .stall (if_id_stall1),
    .nop   (if_id_nop1),
    .d     (fetch1),
    .q     (if_id1)
  );

  operand_decoder i_dec0 (
    .opcode (if_id0.opcode),
    .dec    (dec0)
  );

  operand_decoder i_dec1 (
    .opcode (if_id1.opcode),
    .dec    (dec1)
  );

endmodule

`default_nettype wire

// ==== hdl/hazard_detection_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module hazard_detection_unit (
  input  pipe_pkg::ex_entry_t   id_ex,
  input  logic                  first,
  input  isa_pkg::instr_t       if_id0,
  input  isa_pkg::instr_t       if_id1,
  input  isa_pkg::decoded_t     dec0,
  input  isa_pkg::decoded_t     dec1,
  output pipe_pkg::hazard_ctl_t ctl
);

  import isa_pkg::*;
  import pipe_pkg::*;

  localparam pipe_mask_t FULL_STALL  = PIPE_PC | PIPE_IF_ID | PIPE_ID_EX;
  localparam pipe_mask_t FETCH_STALL = PIPE_PC | PIPE_IF_ID;

  // true when a register read by one slot is written by the other.
  function automatic logic reads_written(
    input instr_t        reader,
    input operand_mask_t src,
    input instr_t        writer,
    input operand_mask_t dst
  );
    logic hit;
    hit = 1'b0;
    if (src.rs && dst.rt && (reader.rs == writer.rt)) begin
      hit = 1'b1;
    end
    if (src.rs && dst.rd && (reader.rs == writer.rd)) begin
      hit = 1'b1;
    end
    if (src.rt && dst.rt && (reader.rt == writer.rt)) begin
      hit = 1'b1;
    end
    if (src.rt && dst.rd && (reader.rt == writer.rd)) begin
      hit = 1'b1;
    end
    return hit;
  endfunction

  logic load_rt_hit;
  logic load_use;
  logic pair_dep;

  // raw field compare against the load target.
  assign load_rt_hit = (id_ex.instr.rt == if_id0.rs) ||
                       (id_ex.instr.rt == if_id0.rt) ||
                       (id_ex.instr.rt == if_id1.rs) ||
                       (id_ex.instr.rt == if_id1.rt);

  assign load_use = (id_ex.mem_op == MEM_READ) && load_rt_hit;

  // older slot reads what the younger one writes.
  assign pair_dep = first ? reads_written(if_id0, dec0.src, if_id1, dec1.dst)
                          : reads_written(if_id1, dec1.src, if_id0, dec0.dst);

  always_comb begin
    ctl = '0;

    if (load_use) begin
      ctl.stall0 = FULL_STALL;
      ctl.nop0   = PIPE_ID_EX;
      ctl.stall1 = FULL_STALL;
      ctl.nop1   = PIPE_ID_EX;
    end else if (pair_dep) begin
      if (first) begin // slot 1 is younger.
        ctl.stall1 = FULL_STALL;
        ctl.nop1   = PIPE_ID_EX;
        ctl.stall0 = FETCH_STALL;
        ctl.nop0   = PIPE_IF_ID;
      end else begin
        ctl.stall0 = FULL_STALL;
        ctl.nop0   = PIPE_ID_EX;
        ctl.stall1 = FETCH_STALL;
        ctl.nop1   = PIPE_IF_ID;
      end
    end
  end

  // the older slot moves on to ID/EX and leaves a bubble in IF/ID,
  // the younger one waits in IF/ID for the next cycle.

endmodule

`default_nettype wire

// ==== hdl/issue_pair_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module issue_pair_top #(
  parameter logic [31:0] RESET_PC = 32'h0
) (
  input  logic                  clk,
  input  logic                  rst,
  input  isa_pkg::instr_t       fetch0,
  input  isa_pkg::instr_t       fetch1,
  input  logic                  first,
  output logic [31:0]           pc,
  output pipe_pkg::ex_entry_t   ex0,
  output pipe_pkg::ex_entry_t   ex1,
  output pipe_pkg::hazard_ctl_t ctl
);

  import isa_pkg::*;
  import pipe_pkg::*;

  instr_t    if_id0;
  instr_t    if_id1;
  logic      if_id_first;
  decoded_t  dec0;
  decoded_t  dec1;
  ex_entry_t id_ex0_d;
  ex_entry_t id_ex1_d;
  logic      id_ex_stall0;
  logic      id_ex_stall1;
  logic      id_ex_nop0;
  logic      id_ex_nop1;

  assign id_ex0_d = '{instr: if_id0, mem_op: dec0.mem_op};
  assign id_ex1_d = '{instr: if_id1, mem_op: dec1.mem_op};

  assign id_ex_stall0 = |(ctl.stall0 & PIPE_ID_EX);
  assign id_ex_stall1 = |(ctl.stall1 & PIPE_ID_EX);
  assign id_ex_nop0   = |(ctl.nop0 & PIPE_ID_EX);
  assign id_ex_nop1   = |(ctl.nop1 & PIPE_ID_EX);

  decode_stage #(
    .RESET_PC (RESET_PC)
  ) i_decode_stage (
    .clk         (clk),
    .rst         (rst),
    .fetch0      (fetch0),
    .fetch1      (fetch1),
    .first       (first),
    .ctl         (ctl),
    .pc          (pc),
    .if_id0      (if_id0),
    .if_id1      (if_id1),
    .if_id_first (if_id_first),
    .dec0        (dec0),
    .dec1        (dec1)
  );

  // only slot 0 carries memory ops, so only ex0 is checked for load-use.
  hazard_detection_unit i_hazard_detection_unit (
    .id_ex  (ex0),
    .first  (if_id_first),
    .if_id0 (if_id0),
    .if_id1 (if_id1),
    .dec0   (dec0),
    .dec1   (dec1),
    .ctl    (ctl)
  );

  pipe_stage_reg #(
    .payload_t (ex_entry_t),
    .BUBBLE    (BUBBLE_EX)
  ) i_id_ex0_reg (
    .clk   (clk),
    .rst   (rst),
    .stall (id_ex_stall0),
    .nop   (id_ex_nop0),
    .d     (id_ex0_d),
    .q     (ex0)
  );

  pipe_stage_reg #(
    .payload_t (ex_entry_t),
    .BUBBLE    (BUBBLE_EX)
  ) i_id_ex1_reg (
    .clk   (clk),
    .rst   (rst),
    .stall (id_ex_stall1),
    .nop   (id_ex_nop1),
    .d     (id_ex1_d),
    .q     (ex1)
  );

endmodule

`default_nettype wire

// ==== test/issue_pair_checker.sv ====
`timescale 1ns/100ps
`default_nettype none

module issue_pair_checker (
  input logic                  clk,
  input logic                  rst,
  input pipe_pkg::hazard_ctl_t ctl
);

  import pipe_pkg::*;

  logic pc_stall0;
  logic pc_stall1;

  assign pc_stall0 = (ctl.stall0 & PIPE_PC) != '0;
  assign pc_stall1 = (ctl.stall1 & PIPE_PC) != '0;

  nop0_has_stall: assert property (@(posedge clk) disable iff (rst)
    (ctl.nop0 & ~ctl.stall0) == '0)
    else $error("slot 0 nop bit set without its stall bit");

  nop1_has_stall: assert property (@(posedge clk) disable iff (rst)
    (ctl.nop1 & ~ctl.stall1) == '0)
    else $error("slot 1 nop bit set without its stall bit");

  // fetch is frozen for the pair or not at all.
  pc_stall_shared: assert property (@(posedge clk) disable iff (rst)
    pc_stall0 == pc_stall1)
    else $error("pc stall present in only one slot");

  quiet_in_reset: assert property (@(posedge clk)
    rst && $past(rst) |-> ctl == '0)
    else $error("hazard control active during reset");

endmodule

// ctl of the top is the hazard unit's output.
bind issue_pair_top issue_pair_checker i_issue_pair_checker (
  .clk (clk),
  .rst (rst),
  .ctl (ctl)
);

`default_nettype wire

// ==== test/issue_pair_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module issue_pair_tb;

  import isa_pkg::*;
  import pipe_pkg::*;

  localparam int CYCLES       = 400;
  localparam int EDGE_TIMEOUT = 100; // ns allowed per clock edge.

  logic        clk;
  logic        rst;
  instr_t      fetch0;
  instr_t      fetch1;
  logic        first;
  logic [31:0] pc;
  ex_entry_t   ex0;
  ex_entry_t   ex1;
  hazard_ctl_t ctl;

  logic [31:0] rng_state;
  int          errors;
  int          hits[4]; // load-use, pair first high, pair first low, clear.

  logic [31:0] m_pc; // reference model state.
  instr_t      m_if0;
  instr_t      m_if1;
  logic        m_first;
  ex_entry_t   m_ex0;
  ex_entry_t   m_ex1;

  issue_pair_top #(
    .RESET_PC (32'h0)
  ) i_issue_pair_top (
    .clk    (clk),
    .rst    (rst),
    .fetch0 (fetch0),
    .fetch1 (fetch1),
    .first  (first),
    .pc     (pc),
    .ex0    (ex0),
    .ex1    (ex1),
    .ctl    (ctl)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_random();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  function automatic operand_mask_t reads_of(input opcode_t op);
    operand_mask_t m;
    m = '0;
    case (op[5:4])
      2'b00: begin
        m.rs = (op != OP_NOP);
        m.rt = (op != OP_NOP) && (op != OP_JR);
      end
      2'b01: m.rs = 1'b1;
      2'b10: begin
        m.rs = (op == OP_LW) || (op == OP_SW);
        m.rt = (op == OP_SW) || (op == OP_SA);
      end
      default: m = '0;
    endcase
    return m;
  endfunction

  function automatic operand_mask_t writes_of(input opcode_t op);
    operand_mask_t m;
    m    = '0;
    m.rd = (op[5:4] == 2'b00) && (op != OP_NOP) && (op != OP_JR);
    m.rt = (op[5:4] == 2'b01) || (op == OP_LW) || (op == OP_LA);
    return m;
  endfunction

  function automatic mem_op_t mem_of(input opcode_t op);
    if (op == OP_LW) return MEM_READ;
    if ((op == OP_SW) || (op == OP_SA)) return MEM_WRITE;
    return MEM_NONE;
  endfunction

  function automatic logic conflict(input instr_t older, input instr_t younger);
    operand_mask_t r;
    operand_mask_t w;
    r = reads_of(older.opcode);
    w = writes_of(younger.opcode);
    return (r.rs && w.rt && (older.rs == younger.rt)) ||
           (r.rs && w.rd && (older.rs == younger.rd)) ||
           (r.rt && w.rt && (older.rt == younger.rt)) ||
           (r.rt && w.rd && (older.rt == younger.rd));
  endfunction

  function automatic hazard_ctl_t expected_ctl();
    hazard_ctl_t c;
    reg_idx_t    t;
    logic        load_use;
    t        = m_ex0.instr.rt;
    load_use = (m_ex0.mem_op == MEM_READ) &&
               ((t == m_if0.rs) || (t == m_if0.rt) || (t == m_if1.rs) || (t == m_if1.rt));
    c = '0;
    if (load_use) begin
      c.stall0 = PIPE_PC | PIPE_IF_ID | PIPE_ID_EX;
      c.stall1 = c.stall0;
      c.nop0   = PIPE_ID_EX;
      c.nop1   = PIPE_ID_EX;
    end else if (m_first ? conflict(m_if0, m_if1) : conflict(m_if1, m_if0)) begin
      if (m_first) begin // slot 1 waits.
        c.stall1 = PIPE_PC | PIPE_IF_ID | PIPE_ID_EX;
        c.nop1   = PIPE_ID_EX;
        c.stall0 = PIPE_PC | PIPE_IF_ID;
        c.nop0   = PIPE_IF_ID;
      end else begin
        c.stall0 = PIPE_PC | PIPE_IF_ID | PIPE_ID_EX;
        c.nop0   = PIPE_ID_EX;
        c.stall1 = PIPE_PC | PIPE_IF_ID;
        c.nop1   = PIPE_IF_ID;
      end
    end
    return c;
  endfunction

  function automatic instr_t random_instr(input logic mem_slot);
    instr_t      ins;
    logic [31:0] r;
    r = next_random();
    case (r[7:0] % (mem_slot ? 10 : 5))
      0: ins.opcode = OP_NOP;
      1: ins.opcode = OP_JR;
      2: ins.opcode = 6'd1 + 6'(r[15:8] % 7); // reg alu, skips NOP and JR.
      3: ins.opcode = {2'b01, r[11:8]};
      4: ins.opcode = {2'b11, r[11:8]};
      5: ins.opcode = OP_LW;
      6: ins.opcode = OP_SW;
      7: ins.opcode = OP_LA;
      8: ins.opcode = OP_SA;
      default: ins.opcode = 6'b101111; // unused memory encoding.
    endcase
    ins.rs = reg_idx_t'(r[17:16]);
    ins.rt = reg_idx_t'(r[19:18]);
    ins.rd = reg_idx_t'(r[21:20]);
    return ins;
  endfunction

  task automatic check_value(input string what, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      errors++;
      $display("FAIL %0d ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic step_model(input instr_t f0, input instr_t f1, input logic fst,
                            input hazard_ctl_t c);
    ex_entry_t n0;
    ex_entry_t n1;
    n0 = '{instr: m_if0, mem_op: mem_of(m_if0.opcode)};
    n1 = '{instr: m_if1, mem_op: mem_of(m_if1.opcode)};
    if ((c.nop0 & PIPE_ID_EX) != 0) m_ex0 = BUBBLE_EX;
    else if ((c.stall0 & PIPE_ID_EX) == 0) m_ex0 = n0;
    if ((c.nop1 & PIPE_ID_EX) != 0) m_ex1 = BUBBLE_EX;
    else if ((c.stall1 & PIPE_ID_EX) == 0) m_ex1 = n1;
    if ((c.stall0 & PIPE_IF_ID) == 0) m_first = fst;
    if ((c.nop0 & PIPE_IF_ID) != 0) m_if0 = BUBBLE_INSTR;
    else if ((c.stall0 & PIPE_IF_ID) == 0) m_if0 = f0;
    if ((c.nop1 & PIPE_IF_ID) != 0) m_if1 = BUBBLE_INSTR;
    else if ((c.stall1 & PIPE_IF_ID) == 0) m_if1 = f1;
    if (((c.stall0 | c.stall1) & PIPE_PC) == 0) m_pc = m_pc + 32'd2;
  endtask

  task automatic wait_falls(input int n, output logic ok);
    logic seen;
    ok = 1'b1;
    for (int i = 0; (i < n) && ok; i++) begin
      seen = 1'b0;
      fork
        begin
          @(negedge clk);
          seen = 1'b1;
        end
        #(EDGE_TIMEOUT);
      join_any
      disable fork;
      if (!seen) begin
        ok = 1'b0;
        errors++;
        $display("timeout: clock stopped, no falling edge at %0d ns", $time);
      end
    end
  endtask

  initial begin
    hazard_ctl_t exp_ctl;
    instr_t      pair0;
    instr_t      pair1;
    logic        pair_first;
    logic        pc_held;
    logic        ok;
    logic [31:0] r;
    rst       = 1'b1;
    fetch0    = BUBBLE_INSTR;
    fetch1    = BUBBLE_INSTR;
    first     = 1'b1;
    rng_state = 32'hc1c4_6b98;
    errors    = 0;
    hits      = '{default: 0};
    m_pc      = 32'h0;
    m_if0     = BUBBLE_INSTR;
    m_if1     = BUBBLE_INSTR;
    m_first   = 1'b0;
    m_ex0     = BUBBLE_EX;
    m_ex1     = BUBBLE_EX;
    pc_held   = 1'b0;
    wait_falls(3, ok);
    rst = 1'b0;
    for (int cyc = 0; (cyc < CYCLES) && ok; cyc++) begin
      exp_ctl = expected_ctl();
      check_value("pc", pc, m_pc);
      check_value("ex0", ex0, m_ex0);
      check_value("ex1", ex1, m_ex1);
      check_value("ctl", ctl, exp_ctl);
      if (exp_ctl == '0) hits[3]++;
      else if (exp_ctl.nop0 == exp_ctl.nop1) hits[0]++;
      else if (exp_ctl.nop1 == PIPE_ID_EX) hits[1]++;
      else hits[2]++;
      if (!pc_held) begin // same pair again while the pc holds.
        pair0      = random_instr(1'b1);
        pair1      = random_instr(1'b0);
        r          = next_random();
        pair_first = r[0];
      end
      fetch0  = pair0;
      fetch1  = pair1;
      first   = pair_first;
      pc_held = ((exp_ctl.stall0 | exp_ctl.stall1) & PIPE_PC) != 0;
      step_model(pair0, pair1, pair_first, exp_ctl);
      wait_falls(1, ok);
    end
    foreach (hits[k]) begin
      if (ok && (hits[k] == 0)) begin
        errors++;
        $display("hazard case %0d (load-use, first high, first low, clear) never seen", k);
      end
    end
    $display("checked %0d cycles, %0d errors", CYCLES, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== dual_hazard.f ====
hdl/isa_pkg.sv
hdl/pipe_pkg.sv
hdl/operand_decoder.sv
hdl/pipe_stage_reg.sv
hdl/decode_stage.sv
hdl/hazard_detection_unit.sv
hdl/issue_pair_top.sv
test/issue_pair_checker.sv
test/issue_pair_tb.sv

// ==== Bender.yml ====
package:
  name: dual_hazard

sources:
  - files:
      - hdl/isa_pkg.sv
      - hdl/pipe_pkg.sv
      - hdl/operand_decoder.sv
      - hdl/pipe_stage_reg.sv
      - hdl/decode_stage.sv
      - hdl/hazard_detection_unit.sv
      - hdl/issue_pair_top.sv
  - target: test
    files:
      - test/issue_pair_checker.sv
      - test/issue_pair_tb.sv
